/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := dmc_tb
FILELIST  := sim.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Test FAILED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation reported a failure"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* logic/dmc_axi_bridge.sv */
module dmc_axi_bridge
 #(parameter  ui_data_width_p   = 32
  ,localparam ui_mask_width_lp  = ui_data_width_p >> 3
  ,localparam offset_width_lp   = $clog2(ui_mask_width_lp)
  ,localparam axi_addr_width_lp = dmc_pkg::ui_addr_width_c + offset_width_lp)
  (input  logic                         ui_clk_i
  ,input  logic                         rst_n_i
  ,dmc_cmd_if.dst                       cmd_i
  // Write address and data
  ,output logic [axi_addr_width_lp-1:0] axi_awaddr_o
  ,output logic                         axi_awvalid_o
  ,input  logic                         axi_awready_i
  ,output logic   [ui_data_width_p-1:0] axi_wdata_o
  ,output logic  [ui_mask_width_lp-1:0] axi_wstrb_o
  ,output logic                         axi_wvalid_o
  ,input  logic                         axi_wready_i
  // Write response
  ,input  logic                         axi_bvalid_i
  ,input  logic                   [1:0] axi_bresp_i
  ,output logic                         axi_bready_o
  // Read address and data
  ,output logic [axi_addr_width_lp-1:0] axi_araddr_o
  ,output logic                         axi_arvalid_o
  ,input  logic                         axi_arready_i
  ,input  logic   [ui_data_width_p-1:0] axi_rdata_i
  ,input  logic                         axi_rvalid_i
  ,output logic                         axi_rready_o
  // Read return to the app side
  ,output logic                         app_rd_data_valid_o
  ,output logic   [ui_data_width_p-1:0] app_rd_data_o
  );

  import dmc_pkg::*;

  typedef enum logic [2:0] {IDLE, WR_ADDR, WR_RESP, RD_ADDR, RD_DATA} state_e;

  state_e state_q, state_n;

  // Row latched by ACT for each bank
  logic [num_banks_c-1:0] bank_open_q;
  logic [row_width_c-1:0] bank_row_q [num_banks_c];

  logic take;
  logic aw_fire;
  logic w_fire;
  logic aw_done_q;
  logic w_done_q;
  logic aw_done_n;
  logic w_done_n;

  logic [axi_addr_width_lp-1:0] addr_q;
  logic   [ui_data_width_p-1:0] wdata_q;
  logic  [ui_mask_width_lp-1:0] wstrb_q;
  logic                         rd_valid_q;
  logic   [ui_data_width_p-1:0] rd_data_q;

  assign cmd_i.ready = (state_q == IDLE);
  assign take        = cmd_i.valid & cmd_i.ready;

  assign axi_awvalid_o = (state_q == WR_ADDR) & ~aw_done_q;
  assign axi_wvalid_o  = (state_q == WR_ADDR) & ~w_done_q;
  assign axi_bready_o  = (state_q == WR_RESP);
  assign axi_arvalid_o = (state_q == RD_ADDR);
  assign axi_rready_o  = (state_q == RD_DATA);

  assign axi_awaddr_o = addr_q;
  assign axi_araddr_o = addr_q;
  assign axi_wdata_o  = wdata_q;
  assign axi_wstrb_o  = wstrb_q;

  assign app_rd_data_valid_o = rd_valid_q;
  assign app_rd_data_o       = rd_data_q;

  assign aw_fire   = axi_awvalid_o & axi_awready_i;
  assign w_fire    = axi_wvalid_o & axi_wready_i;
  assign aw_done_n = aw_done_q | aw_fire;
  assign w_done_n  = w_done_q | w_fire;

  always_comb begin
    state_n = state_q;
    case (state_q)
      IDLE: begin
        if (take && cmd_i.cmd == WR) begin
          state_n = WR_ADDR;
        end else if (take && cmd_i.cmd == RD) begin
          state_n = RD_ADDR;
        end
      end
      WR_ADDR: if (aw_done_n && w_done_n) state_n = WR_RESP;
      WR_RESP: if (axi_bvalid_i) state_n = IDLE;
      RD_ADDR: if (axi_arready_i) state_n = RD_DATA;
      RD_DATA: if (axi_rvalid_i) state_n = IDLE;
      default: state_n = IDLE;
    endcase
  end

  always_ff @(posedge ui_clk_i) begin
    if (!rst_n_i) begin
      state_q     <= IDLE;
      bank_open_q <= '0;
      aw_done_q   <= 1'b0;
      w_done_q    <= 1'b0;
      rd_valid_q  <= 1'b0;
    end else begin
      state_q    <= state_n;
      aw_done_q  <= (state_n == WR_ADDR) & aw_done_n;
      w_done_q   <= (state_n == WR_ADDR) & w_done_n;
      rd_valid_q <= (state_q == RD_DATA) & axi_rvalid_i;
      if (take && cmd_i.cmd == ACT) begin
        bank_open_q[cmd_i.bank] <= 1'b1;
      end
      if (take && cmd_i.cmd == PRE) begin
        bank_open_q[cmd_i.bank] <= 1'b0;
      end
    end
  end

  always_ff @(posedge ui_clk_i) begin
    if (take && cmd_i.cmd == ACT) begin
      bank_row_q[cmd_i.bank] <= cmd_i.row;
    end
    // Address rebuilt from the latched row, not the entry row
    if (take && (cmd_i.cmd == WR || cmd_i.cmd == RD)) begin
      addr_q <= {cmd_i.bank, bank_row_q[cmd_i.bank], cmd_i.col, {offset_width_lp{1'b0}}};
    end
    if (take && cmd_i.cmd == WR) begin
      wdata_q <= cmd_i.wrdata;
      wstrb_q <= ~cmd_i.wrmask;
    end
    if (state_q == RD_DATA && axi_rvalid_i) begin
      rd_data_q <= axi_rdata_i;
    end
  end

endmodule

/* logic/dmc_cmd_fifo.sv */
module dmc_cmd_fifo
 #(parameter  ui_data_width_p  = 32
  ,parameter  fifo_depth_p     = 4
  ,localparam ui_mask_width_lp = ui_data_width_p >> 3
  ,localparam ptr_width_lp     = (fifo_depth_p > 1) ? $clog2(fifo_depth_p) : 1
  ,localparam cnt_width_lp     = $clog2(fifo_depth_p + 1))
  (input  logic   ui_clk_i
  ,input  logic   rst_n_i
  ,dmc_cmd_if.dst enq_i
  ,dmc_cmd_if.src deq_o
  );

  import dmc_pkg::*;

  dfi_cmd_e                    cmd_mem    [fifo_depth_p];
  logic     [bank_width_c-1:0] bank_mem   [fifo_depth_p];
  logic      [row_width_c-1:0] row_mem    [fifo_depth_p];
  logic      [col_width_c-1:0] col_mem    [fifo_depth_p];
  logic  [ui_data_width_p-1:0] wrdata_mem [fifo_depth_p];
  logic [ui_mask_width_lp-1:0] wrmask_mem [fifo_depth_p];

  logic [ptr_width_lp-1:0] wr_ptr_q;
  logic [ptr_width_lp-1:0] rd_ptr_q;
  logic [cnt_width_lp-1:0] count_q;
  logic                    enq_fire;
  logic                    deq_fire;

  assign enq_i.ready = (count_q != cnt_width_lp'(fifo_depth_p));
  assign deq_o.valid = (count_q != '0);

  assign enq_fire = enq_i.valid & enq_i.ready;
  assign deq_fire = deq_o.valid & deq_o.ready;

  assign deq_o.cmd    = cmd_mem[rd_ptr_q];
  assign deq_o.bank   = bank_mem[rd_ptr_q];
  assign deq_o.row    = row_mem[rd_ptr_q];
  assign deq_o.col    = col_mem[rd_ptr_q];
  assign deq_o.wrdata = wrdata_mem[rd_ptr_q];
  assign deq_o.wrmask = wrmask_mem[rd_ptr_q];

  function automatic logic [ptr_width_lp-1:0] ptr_inc(input logic [ptr_width_lp-1:0] ptr);
    logic [ptr_width_lp-1:0] nxt;
    nxt = (ptr == ptr_width_lp'(fifo_depth_p - 1)) ? '0 : ptr + 1'b1;
    return nxt;
  endfunction

  always_ff @(posedge ui_clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (enq_fire) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (deq_fire) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      // Simultaneous push and pop leaves the count unchanged
      if (enq_fire && !deq_fire) begin
        count_q <= count_q + 1'b1;
      end else if (deq_fire && !enq_fire) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge ui_clk_i) begin
    if (enq_fire) begin
      cmd_mem[wr_ptr_q]    <= enq_i.cmd;
      bank_mem[wr_ptr_q]   <= enq_i.bank;
      row_mem[wr_ptr_q]    <= enq_i.row;
      col_mem[wr_ptr_q]    <= enq_i.col;
      wrdata_mem[wr_ptr_q] <= enq_i.wrdata;
      wrmask_mem[wr_ptr_q] <= enq_i.wrmask;
    end
  end

endmodule

/* logic/dmc_cmd_gen.sv */
module dmc_cmd_gen
 #(parameter  ui_data_width_p  = 32
  ,localparam ui_mask_width_lp = ui_data_width_p >> 3)
  (input  logic                                ui_clk_i
  ,input  logic                                rst_n_i
  ,input  logic                                app_en_i
  ,input  dmc_pkg::dmc_app_cmd_e               app_cmd_i
  ,input  logic [dmc_pkg::ui_addr_width_c-1:0] app_addr_i
  ,input  logic          [ui_data_width_p-1:0] app_wdf_data_i
  ,input  logic         [ui_mask_width_lp-1:0] app_wdf_mask_i
  ,output logic                                app_rdy_o
  ,dmc_cmd_if.src                              cmd_o
  );

  import dmc_pkg::*;

  typedef enum logic [1:0] {IDLE, PRECHARGE, ACTIVATE, ACCESS} state_e;

  state_e state_q, state_n;

  // Open-page bookkeeping, one row per bank
  logic [num_banks_c-1:0] open_q;
  logic [row_width_c-1:0] open_row_q [num_banks_c];

  logic [bank_width_c-1:0] req_bank;
  logic  [row_width_c-1:0] req_row;
  logic  [col_width_c-1:0] req_col;
  logic                    req_cmd_ok;
  logic                    accept;
  logic                    fire;

  logic     [bank_width_c-1:0] bank_q;
  logic      [row_width_c-1:0] row_q;
  logic      [col_width_c-1:0] col_q;
  dfi_cmd_e                    access_q;
  logic  [ui_data_width_p-1:0] wrdata_q;
  logic [ui_mask_width_lp-1:0] wrmask_q;

  assign req_bank   = app_addr_i[bank_lsb_c +: bank_width_c];
  assign req_row    = app_addr_i[row_lsb_c +: row_width_c];
  assign req_col    = app_addr_i[col_lsb_c +: col_width_c];
  assign req_cmd_ok = (app_cmd_i == WRITE) || (app_cmd_i == READ);

  assign app_rdy_o = (state_q == IDLE);
  assign accept    = app_en_i & app_rdy_o & req_cmd_ok;
  assign fire      = cmd_o.valid & cmd_o.ready;

  always_comb begin
    state_n = state_q;
    case (state_q)
      IDLE: begin
        if (accept) begin
          if (!open_q[req_bank]) begin
            state_n = ACTIVATE;
          end else if (open_row_q[req_bank] != req_row) begin
            state_n = PRECHARGE;
          end else begin
            state_n = ACCESS;
          end
        end
      end
      PRECHARGE: if (fire) state_n = ACTIVATE;
      ACTIVATE:  if (fire) state_n = ACCESS;
      ACCESS:    if (fire) state_n = IDLE;
      default:   state_n = IDLE;
    endcase
  end

  always_comb begin
    cmd_o.valid  = (state_q != IDLE);
    cmd_o.bank   = bank_q;
    cmd_o.row    = row_q;
    cmd_o.col    = col_q;
    cmd_o.wrdata = wrdata_q;
    cmd_o.wrmask = wrmask_q;
    case (state_q)
      PRECHARGE: cmd_o.cmd = PRE;
      ACTIVATE:  cmd_o.cmd = ACT;
      default:   cmd_o.cmd = access_q;
    endcase
  end

  always_ff @(posedge ui_clk_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      open_q  <= '0;
    end else begin
      state_q <= state_n;
      if (fire && state_q == PRECHARGE) begin
        open_q[bank_q] <= 1'b0;
      end
      if (fire && state_q == ACTIVATE) begin
        open_q[bank_q] <= 1'b1;
      end
    end
  end

  always_ff @(posedge ui_clk_i) begin
    if (accept) begin
      bank_q   <= req_bank;
      row_q    <= req_row;
      col_q    <= req_col;
      access_q <= (app_cmd_i == WRITE) ? WR : RD;
      wrdata_q <= app_wdf_data_i;
      wrmask_q <= app_wdf_mask_i;
    end
    if (fire && state_q == ACTIVATE) begin
      open_row_q[bank_q] <= row_q;
    end
  end

endmodule

/* logic/dmc_cmd_if.sv */
interface dmc_cmd_if
 #(parameter  ui_data_width_p  = 32
  ,localparam ui_mask_width_lp = ui_data_width_p >> 3);

  import dmc_pkg::*;

  logic                        valid;
  logic                        ready;
  dfi_cmd_e                    cmd;
  logic     [bank_width_c-1:0] bank;
  logic      [row_width_c-1:0] row;
  logic      [col_width_c-1:0] col;
  logic  [ui_data_width_p-1:0] wrdata;
  logic [ui_mask_width_lp-1:0] wrmask;

  modport src
    (output valid, cmd, bank, row, col, wrdata, wrmask
    ,input  ready);

  modport dst
    (input  valid, cmd, bank, row, col, wrdata, wrmask
    ,output ready);

endinterface

/* logic/dmc_pkg.sv */
package dmc_pkg;

  // Address field widths
  localparam int bank_width_c    = 2;
  localparam int row_width_c     = 8;
  localparam int col_width_c     = 6;
  localparam int ui_addr_width_c = bank_width_c + row_width_c + col_width_c;
  localparam int num_banks_c     = 1 << bank_width_c;

  // Bank on top, then row, then column
  localparam int col_lsb_c  = 0;
  localparam int row_lsb_c  = col_lsb_c + col_width_c;
  localparam int bank_lsb_c = row_lsb_c + row_width_c;

  // Other app opcode encodings are ignored
  typedef enum logic [2:0] {
    WRITE = 3'd0,
    READ  = 3'd1
  } dmc_app_cmd_e;

  typedef enum logic [1:0] {
    ACT = 2'd0,
    PRE = 2'd1,
    WR  = 2'd2,
    RD  = 2'd3
  } dfi_cmd_e;

endpackage

/* logic/dmc_top.sv */
module dmc_top
 #(parameter  ui_data_width_p   = 32
  ,parameter  fifo_depth_p      = 4
  ,localparam ui_mask_width_lp  = ui_data_width_p >> 3
  ,localparam axi_addr_width_lp = dmc_pkg::ui_addr_width_c + $clog2(ui_mask_width_lp))
  (input  logic                                ui_clk_i
  ,input  logic                                rst_n_i
  // User interface signals
  ,input  logic [dmc_pkg::ui_addr_width_c-1:0] app_addr_i
  ,input  dmc_pkg::dmc_app_cmd_e               app_cmd_i
  ,input  logic                                app_en_i
  ,output logic                                app_rdy_o
  ,input  logic          [ui_data_width_p-1:0] app_wdf_data_i
  ,input  logic         [ui_mask_width_lp-1:0] app_wdf_mask_i
  ,output logic                                app_rd_data_valid_o
  ,output logic          [ui_data_width_p-1:0] app_rd_data_o
  // AXI interface
  ,output logic        [axi_addr_width_lp-1:0] axi_awaddr_o
  ,output logic                                axi_awvalid_o
  ,input  logic                                axi_awready_i
  ,output logic          [ui_data_width_p-1:0] axi_wdata_o
  ,output logic         [ui_mask_width_lp-1:0] axi_wstrb_o
  ,output logic                                axi_wvalid_o
  ,input  logic                                axi_wready_i
  ,input  logic                                axi_bvalid_i
  ,input  logic                          [1:0] axi_bresp_i
  ,output logic                                axi_bready_o
  ,output logic        [axi_addr_width_lp-1:0] axi_araddr_o
  ,output logic                                axi_arvalid_o
  ,input  logic                                axi_arready_i
  ,input  logic          [ui_data_width_p-1:0] axi_rdata_i
  ,input  logic                                axi_rvalid_i
  ,output logic                                axi_rready_o
  );

  dmc_cmd_if #(.ui_data_width_p(ui_data_width_p)) gen_to_fifo ();
  dmc_cmd_if #(.ui_data_width_p(ui_data_width_p)) fifo_to_bridge ();

  dmc_cmd_gen #(.ui_data_width_p(ui_data_width_p)) cmd_gen
    (.ui_clk_i       ( ui_clk_i       )
    ,.rst_n_i        ( rst_n_i        )
    ,.app_en_i       ( app_en_i       )
    ,.app_cmd_i      ( app_cmd_i      )
    ,.app_addr_i     ( app_addr_i     )
    ,.app_wdf_data_i ( app_wdf_data_i )
    ,.app_wdf_mask_i ( app_wdf_mask_i )
    ,.app_rdy_o      ( app_rdy_o      )
    ,.cmd_o          ( gen_to_fifo    ));

  dmc_cmd_fifo #
    (.ui_data_width_p ( ui_data_width_p )
    ,.fifo_depth_p    ( fifo_depth_p    ))
  cmd_fifo
    (.ui_clk_i ( ui_clk_i       )
    ,.rst_n_i  ( rst_n_i        )
    ,.enq_i    ( gen_to_fifo    )
    ,.deq_o    ( fifo_to_bridge ));

  dmc_axi_bridge #(.ui_data_width_p(ui_data_width_p)) axi_bridge
    (.ui_clk_i            ( ui_clk_i            )
    ,.rst_n_i             ( rst_n_i             )
    ,.cmd_i               ( fifo_to_bridge      )
    ,.axi_awaddr_o        ( axi_awaddr_o        )
    ,.axi_awvalid_o       ( axi_awvalid_o       )
    ,.axi_awready_i       ( axi_awready_i       )
    ,.axi_wdata_o         ( axi_wdata_o         )
    ,.axi_wstrb_o         ( axi_wstrb_o         )
    ,.axi_wvalid_o        ( axi_wvalid_o        )
    ,.axi_wready_i        ( axi_wready_i        )
    ,.axi_bvalid_i        ( axi_bvalid_i        )
    ,.axi_bresp_i         ( axi_bresp_i         )
    ,.axi_bready_o        ( axi_bready_o        )
    ,.axi_araddr_o        ( axi_araddr_o        )
    ,.axi_arvalid_o       ( axi_arvalid_o       )
    ,.axi_arready_i       ( axi_arready_i       )
    ,.axi_rdata_i         ( axi_rdata_i         )
    ,.axi_rvalid_i        ( axi_rvalid_i        )
    ,.axi_rready_o        ( axi_rready_o        )
    ,.app_rd_data_valid_o ( app_rd_data_valid_o )
    ,.app_rd_data_o       ( app_rd_data_o       ));

endmodule

/* sim.f */
logic/dmc_pkg.sv
logic/dmc_cmd_if.sv
logic/dmc_cmd_gen.sv
logic/dmc_cmd_fifo.sv
logic/dmc_axi_bridge.sv
logic/dmc_top.sv
verification/dmc_sva.sv
verification/dmc_tb.sv

/* verification/dmc_sva.sv */
module dmc_sva
  (input  logic                               ui_clk_i
  ,input  logic                               rst_n_i
  ,input  logic                               take_i
  ,input  dmc_pkg::dfi_cmd_e                  entry_cmd_i
  ,input  logic [dmc_pkg::bank_width_c-1:0]   entry_bank_i
  ,input  logic [dmc_pkg::num_banks_c-1:0]    bank_open_i
  ,input  logic                               awvalid_i
  ,input  logic                               awready_i
  ,input  logic                               arvalid_i
  ,input  logic                               arready_i
  );

  import dmc_pkg::*;

  int unsigned fail_cnt = 0;

  // Accesses need a row latched by an earlier ACT
  access_to_open_bank: assert property (@(posedge ui_clk_i) disable iff (!rst_n_i)
      take_i && (entry_cmd_i == WR || entry_cmd_i == RD) |-> bank_open_i[entry_bank_i])
    else begin
      $error("WR or RD entry to bank %0d with no latched row", entry_bank_i);
      fail_cnt++;
    end

  awvalid_held: assert property (@(posedge ui_clk_i) disable iff (!rst_n_i)
      awvalid_i && !awready_i |=> awvalid_i)
    else begin
      $error("awvalid dropped before awready");
      fail_cnt++;
    end

  arvalid_held: assert property (@(posedge ui_clk_i) disable iff (!rst_n_i)
      arvalid_i && !arready_i |=> arvalid_i)
    else begin
      $error("arvalid dropped before arready");
      fail_cnt++;
    end

endmodule

bind dmc_axi_bridge dmc_sva bridge_sva
  (.ui_clk_i     ( ui_clk_i      )
  ,.rst_n_i      ( rst_n_i       )
  ,.take_i       ( take          )
  ,.entry_cmd_i  ( cmd_i.cmd     )
  ,.entry_bank_i ( cmd_i.bank    )
  ,.bank_open_i  ( bank_open_q   )
  ,.awvalid_i    ( axi_awvalid_o )
  ,.awready_i    ( axi_awready_i )
  ,.arvalid_i    ( axi_arvalid_o )
  ,.arready_i    ( axi_arready_i ));

/* verification/dmc_tb.sv */
module dmc_tb;

  import dmc_pkg::*;

  localparam int data_width_lp     = 32;
  localparam int mask_width_lp     = data_width_lp / 8;
  localparam int fifo_depth_lp     = 4;
  localparam int axi_addr_width_lp = ui_addr_width_c + 2;
  // About 30 requests of up to 3 entries and 15 stall cycles each fit well below this
  localparam int timeout_cycles_lp = 5000;

  logic ui_clk = 1'b0;
  logic rst_n;
  logic app_en;
  dmc_app_cmd_e app_cmd;
  logic [ui_addr_width_c-1:0] app_addr;
  logic [data_width_lp-1:0] app_wdf_data;
  logic [mask_width_lp-1:0] app_wdf_mask;
  logic app_rdy;
  logic app_rd_data_valid;
  logic [data_width_lp-1:0] app_rd_data;

  logic [axi_addr_width_lp-1:0] axi_awaddr;
  logic [axi_addr_width_lp-1:0] axi_araddr;
  logic [data_width_lp-1:0] axi_wdata;
  logic [mask_width_lp-1:0] axi_wstrb;
  logic axi_awvalid;
  logic axi_wvalid;
  logic axi_bready;
  logic axi_arvalid;
  logic axi_rready;
  logic axi_awready = 1'b0;
  logic axi_wready = 1'b0;
  logic axi_bvalid = 1'b0;
  logic [1:0] axi_bresp = 2'b00;
  logic axi_arready = 1'b0;
  logic axi_rvalid = 1'b0;
  logic [data_width_lp-1:0] axi_rdata = '0;

  logic [1:0] aw_wait, w_wait, b_wait, ar_wait, r_wait;
  logic aw_got, w_got, ar_got;
  logic [31:0] stall_rng = 32'd30;
  logic [31:0] data_rng = 32'd30;

  logic [data_width_lp-1:0] axi_mem [logic [axi_addr_width_lp-1:0]];
  logic [data_width_lp-1:0] ref_mem [logic [ui_addr_width_c-1:0]];
  logic [data_width_lp-1:0] exp_q [$];
  logic [data_width_lp-1:0] rd_exp;
  logic [axi_addr_width_lp-1:0] aw_exp_q [$];
  logic [axi_addr_width_lp-1:0] ar_exp_q [$];
  logic [axi_addr_width_lp-1:0] addr_exp;

  int err_cnt = 0;
  int check_cnt = 0;
  int test_cnt = 0;
  int cycle_cnt = 0;

  dmc_top #(.ui_data_width_p(data_width_lp), .fifo_depth_p(fifo_depth_lp)) dmc_top_inst
    (.ui_clk_i(ui_clk), .rst_n_i(rst_n)
    ,.app_addr_i(app_addr), .app_cmd_i(app_cmd), .app_en_i(app_en), .app_rdy_o(app_rdy)
    ,.app_wdf_data_i(app_wdf_data), .app_wdf_mask_i(app_wdf_mask)
    ,.app_rd_data_valid_o(app_rd_data_valid), .app_rd_data_o(app_rd_data)
    ,.axi_awaddr_o(axi_awaddr), .axi_awvalid_o(axi_awvalid), .axi_awready_i(axi_awready)
    ,.axi_wdata_o(axi_wdata), .axi_wstrb_o(axi_wstrb), .axi_wvalid_o(axi_wvalid)
    ,.axi_wready_i(axi_wready), .axi_bvalid_i(axi_bvalid), .axi_bresp_i(axi_bresp)
    ,.axi_bready_o(axi_bready), .axi_araddr_o(axi_araddr), .axi_arvalid_o(axi_arvalid)
    ,.axi_arready_i(axi_arready), .axi_rdata_i(axi_rdata), .axi_rvalid_i(axi_rvalid)
    ,.axi_rready_o(axi_rready));

  always #5 ui_clk = ~ui_clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [1:0] next_stall();
    stall_rng = xorshift32(stall_rng);
    return stall_rng[1:0];
  endfunction

  function automatic logic [31:0] next_data();
    data_rng = xorshift32(data_rng);
    return data_rng;
  endfunction

  // Untouched memory returns a pattern of the full byte address
  function automatic logic [data_width_lp-1:0] fill_word(input logic [axi_addr_width_lp-1:0] a);
    return {a, a[17:4]} ^ 32'h5A3C_96E1;
  endfunction

  function automatic logic [data_width_lp-1:0] merge_bytes(input logic [data_width_lp-1:0] old,
      input logic [data_width_lp-1:0] data, input logic [mask_width_lp-1:0] en);
    logic [data_width_lp-1:0] word;
    word = old;
    for (int b = 0; b < mask_width_lp; b++) begin
      if (en[b]) word[8*b +: 8] = data[8*b +: 8];
    end
    return word;
  endfunction

  function automatic logic [data_width_lp-1:0] load_word(input logic [axi_addr_width_lp-1:0] a);
    return axi_mem.exists(a) ? axi_mem[a] : fill_word(a);
  endfunction

  function automatic logic [data_width_lp-1:0] ref_read(input logic [ui_addr_width_c-1:0] a);
    return ref_mem.exists(a) ? ref_mem[a] : fill_word({a, 2'b00});
  endfunction

  function automatic logic [ui_addr_width_c-1:0] make_addr(input logic [1:0] bank,
      input logic [7:0] row, input logic [5:0] col);
    return {bank, row, col};
  endfunction

  function automatic void report_error(input string msg);
    err_cnt++;
    $display("[ERROR] %0t: %s", $time, msg);
  endfunction

  function automatic void compare_addr(input string chan,
      input logic [axi_addr_width_lp-1:0] got, input logic [axi_addr_width_lp-1:0] exp);
    check_cnt++;
    if (got !== exp) report_error($sformatf("%s %h, expected %h", chan, got, exp));
  endfunction

  // AXI slave with random ready and response delays
  always @(posedge ui_clk) begin
    if (!rst_n) begin
      axi_awready <= 1'b0;
      axi_wready  <= 1'b0;
      axi_bvalid  <= 1'b0;
      axi_arready <= 1'b0;
      axi_rvalid  <= 1'b0;
      {aw_got, w_got, ar_got} <= 3'b000;
      aw_wait <= next_stall();
      w_wait  <= next_stall();
      b_wait  <= next_stall();
      ar_wait <= next_stall();
      r_wait  <= next_stall();
    end else begin
      if (axi_awvalid && axi_awready) begin
        axi_awready <= 1'b0;
        aw_got      <= 1'b1;
        aw_wait     <= next_stall();
        if (aw_exp_q.size() == 0) begin
          err_cnt++;
          $display("Write address issued at %0t with no write pending", $time);
        end else begin
          addr_exp = aw_exp_q.pop_front();
          compare_addr("awaddr", axi_awaddr, addr_exp);
        end
      end else if (axi_awvalid) begin
        if (aw_wait == 2'd0) axi_awready <= 1'b1;
        else aw_wait <= aw_wait - 2'd1;
      end
      if (axi_wvalid && axi_wready) begin
        axi_wready <= 1'b0;
        w_got      <= 1'b1;
        w_wait     <= next_stall();
        axi_mem[axi_awaddr] = merge_bytes(load_word(axi_awaddr), axi_wdata, axi_wstrb);
      end else if (axi_wvalid) begin
        if (w_wait == 2'd0) axi_wready <= 1'b1;
        else w_wait <= w_wait - 2'd1;
      end
      if (axi_bvalid && axi_bready) begin
        axi_bvalid <= 1'b0;
        aw_got     <= 1'b0;
        w_got      <= 1'b0;
        b_wait     <= next_stall();
      end else if (aw_got && w_got && !axi_bvalid) begin
        if (b_wait == 2'd0) axi_bvalid <= 1'b1;
        else b_wait <= b_wait - 2'd1;
      end
      if (axi_arvalid && axi_arready) begin
        axi_arready <= 1'b0;
        ar_got      <= 1'b1;
        ar_wait     <= next_stall();
        if (ar_exp_q.size() == 0) begin
          err_cnt++;
          $display("Read address issued at %0t with no read pending", $time);
        end else begin
          addr_exp = ar_exp_q.pop_front();
          compare_addr("araddr", axi_araddr, addr_exp);
        end
      end else if (axi_arvalid) begin
        if (ar_wait == 2'd0) axi_arready <= 1'b1;
        else ar_wait <= ar_wait - 2'd1;
      end
      if (axi_rvalid && axi_rready) begin
        axi_rvalid <= 1'b0;
        ar_got     <= 1'b0;
        r_wait     <= next_stall();
      end else if (ar_got && !axi_rvalid) begin
        if (r_wait == 2'd0) begin
          axi_rvalid <= 1'b1;
          axi_rdata  <= load_word(axi_araddr);
        end else begin
          r_wait <= r_wait - 2'd1;
        end
      end
    end
  end

  // Read data must come back in request order
  always @(posedge ui_clk) begin
    if (rst_n && app_rd_data_valid) begin
      if (exp_q.size() == 0) begin
        err_cnt++;
        $display("Read data %h returned at %0t with no read pending", app_rd_data, $time);
      end else begin
        rd_exp = exp_q.pop_front();
        check_cnt++;
        if (app_rd_data !== rd_exp) begin
          report_error($sformatf("read data %h, expected %h", app_rd_data, rd_exp));
        end
      end
    end
  end

  initial begin
    while (cycle_cnt < timeout_cycles_lp) begin
      @(posedge ui_clk);
      cycle_cnt++;
    end
    $display("Timeout: the tests did not finish within %0d cycles", timeout_cycles_lp);
    $display("Test FAILED");
    $finish;
  end

  task automatic issue(input dmc_app_cmd_e cmd, input logic [ui_addr_width_c-1:0] addr,
      input logic [data_width_lp-1:0] data, input logic [mask_width_lp-1:0] mask);
    app_en       <= 1'b1;
    app_cmd      <= cmd;
    app_addr     <= addr;
    app_wdf_data <= data;
    app_wdf_mask <= mask;
    @(posedge ui_clk);
    while (!app_rdy) @(posedge ui_clk);
    // Accepted at this edge
    if (cmd == WRITE) begin
      ref_mem[addr] = merge_bytes(ref_read(addr), data, ~mask);
      aw_exp_q.push_back({addr, 2'b00});
    end else begin
      exp_q.push_back(ref_read(addr));
      ar_exp_q.push_back({addr, 2'b00});
    end
  endtask

  task automatic drain_reads();
    app_en <= 1'b0;
    while (exp_q.size() != 0) @(posedge ui_clk);
  endtask

  task automatic finish_test(input string name, input int errs_before);
    test_cnt++;
    $display("%s: finished with %0d errors", name, err_cnt - errs_before);
  endtask

  task automatic check_reset_state();
    int errs_before;
    errs_before = err_cnt;
    @(posedge ui_clk);
    check_cnt += 6;
    if (app_rdy !== 1'b1) report_error("app_rdy_o is not high after reset");
    if (app_rd_data_valid !== 1'b0) report_error("app_rd_data_valid_o is not low after reset");
    if (axi_awvalid !== 1'b0) report_error("axi_awvalid_o is not low after reset");
    if (axi_wvalid !== 1'b0) report_error("axi_wvalid_o is not low after reset");
    if (axi_arvalid !== 1'b0) report_error("axi_arvalid_o is not low after reset");
    if (axi_bready !== 1'b0 || axi_rready !== 1'b0) report_error("AXI ready high after reset");
    finish_test("check_reset_state", errs_before);
  endtask

  task automatic write_then_read();
    int errs_before;
    errs_before = err_cnt;
    issue(WRITE, make_addr(2'd0, 8'd4, 6'd2), 32'hDEAD_BEEF, 4'h0);
    issue(READ, make_addr(2'd0, 8'd4, 6'd2), '0, 4'hF);
    drain_reads();
    finish_test("write_then_read", errs_before);
  endtask

  task automatic masked_write();
    int errs_before;
    errs_before = err_cnt;
    issue(WRITE, make_addr(2'd3, 8'd12, 6'd7), 32'h1122_3344, 4'h0);
    // Bytes 0 and 2 keep their old value
    issue(WRITE, make_addr(2'd3, 8'd12, 6'd7), 32'hAABB_CCDD, 4'b0101);
    issue(READ, make_addr(2'd3, 8'd12, 6'd7), '0, 4'hF);
    drain_reads();
    finish_test("masked_write", errs_before);
  endtask

  task automatic bank_row_switch();
    int errs_before;
    errs_before = err_cnt;
    issue(WRITE, make_addr(2'd1, 8'd3, 6'd10), 32'hB103_000A, 4'h0);
    issue(WRITE, make_addr(2'd2, 8'd5, 6'd20), 32'hB205_0014, 4'h0);
    issue(WRITE, make_addr(2'd1, 8'd9, 6'd10), 32'hB109_000A, 4'h0);
    issue(READ, make_addr(2'd2, 8'd5, 6'd20), '0, 4'hF);
    issue(READ, make_addr(2'd1, 8'd3, 6'd10), '0, 4'hF);
    issue(READ, make_addr(2'd1, 8'd9, 6'd10), '0, 4'hF);
    issue(READ, make_addr(2'd3, 8'd77, 6'd1), '0, 4'hF);
    drain_reads();
    finish_test("bank_row_switch", errs_before);
  endtask

  task automatic burst_under_stalls();
    int errs_before;
    logic [ui_addr_width_c-1:0] addrs [8];
    logic [31:0] word;
    errs_before = err_cnt;
    for (int i = 0; i < 8; i++) begin
      word = next_data();
      addrs[i] = make_addr(2'(i % 4), word[15:8], 6'(i));
      issue(WRITE, addrs[i], next_data(), 4'h0);
    end
    for (int i = 0; i < 8; i++) begin
      issue(READ, addrs[i], '0, 4'hF);
    end
    drain_reads();
    finish_test("burst_under_stalls", errs_before);
  endtask

  initial begin
    rst_n        <= 1'b0;
    app_en       <= 1'b0;
    app_cmd      <= WRITE;
    app_addr     <= '0;
    app_wdf_data <= '0;
    app_wdf_mask <= '0;
    repeat (4) @(posedge ui_clk);
    rst_n <= 1'b1;
    check_reset_state();
    write_then_read();
    masked_write();
    bank_row_switch();
    burst_under_stalls();
    $display("Summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
             test_cnt, check_cnt, err_cnt, dmc_top_inst.axi_bridge.bridge_sva.fail_cnt);
    if (err_cnt == 0 && dmc_top_inst.axi_bridge.bridge_sva.fail_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
